// ==== design/cdb_arbiter.sv ====
`timescale 1ns/10ps

module cdb_arbiter
   import ls_bus_pkg::*;
(
   input  logic clk,
   input  logic rst_n,

   input  cdb_t load_result,
   input  logic load_valid,
   output logic load_ready,

   input  cdb_t ext_result,
   input  logic ext_valid,
   output logic ext_ready,

   output cdb_t cdb,
   output logic cdb_valid
);

   // set when the external producer won the last granted cycle
   logic ext_last_q;

   logic grant_load;
   logic grant_ext;

   // a lone requester always wins, a contest goes to the one not served last
   assign grant_load = load_valid && (!ext_valid || ext_last_q);
   assign grant_ext  = ext_valid && (!load_valid || !ext_last_q);

   // each side is ready unless the other one holds the bus
   assign load_ready = !grant_ext;
   assign ext_ready  = !grant_load;

   // one result per cycle goes out and back into the queue
   assign cdb       = grant_load ? load_result : ext_result;
   assign cdb_valid = grant_load || grant_ext;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ext_last_q <= 1'b0;
      end else if (grant_ext) begin
         ext_last_q <= 1'b1;
      end else if (grant_load) begin
         ext_last_q <= 1'b0;
      end
   end

endmodule

// ==== design/ls_bus_pkg.sv ====
package ls_bus_pkg;

   import ls_isa_pkg::*;

   // number of entries in the in-order load/store queue
   localparam int lsq_depth = 4;

   // occupancy counter must hold the value lsq_depth itself
   localparam int lsq_cnt_w = $clog2(lsq_depth) + 1;

   // data memory size in words
   localparam int mem_words = 64;

   // word index width, taken from address bits above the byte offset
   localparam int mem_idx_w = $clog2(mem_words);

   // one instruction as handed over by dispatch
   // for a load rt_tag is the destination tag and rt_data/rt_valid are unused
   typedef struct packed {
      ls_op_e                op;
      logic [offset_w-1:0]   offset;
      tag_t                  rs_tag;
      word_t                 rs_data;
      logic                  rs_valid;
      tag_t                  rt_tag;
      word_t                 rt_data;
      logic                  rt_valid;
   } dispatch_t;

   // one result on the common data bus
   typedef struct packed {
      tag_t  tag;
      word_t data;
   } cdb_t;

   // fully resolved memory request from the queue head
   // tag is only meaningful for loads, data only for stores
   typedef struct packed {
      ls_op_e op;
      tag_t   tag;
      word_t  addr;
      word_t  data;
   } mem_req_t;

endpackage

// ==== design/ls_isa_pkg.sv ====
package ls_isa_pkg;

   // instruction level view of the load/store path
   // only word accesses exist, so one bit of opcode is enough
   typedef enum logic {
      op_load  = 1'b0,
      op_store = 1'b1
   } ls_op_e;

   // a tag names the physical destination that produces a value
   localparam int tag_w = 6;

   // operands, addresses and memory words all share this width
   localparam int data_w = 32;

   // immediate offset as it comes from the instruction word
   // it is sign extended to data_w before the add
   localparam int offset_w = 16;

   typedef logic [tag_w-1:0]  tag_t;
   typedef logic [data_w-1:0] word_t;

endpackage

// ==== design/ls_issue_queue.sv ====
`timescale 1ns/10ps

module ls_issue_queue
   import ls_isa_pkg::*, ls_bus_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,

   input  dispatch_t dispatch,
   input  logic      dispatch_valid,
   output logic      dispatch_ready,

   input  cdb_t      cdb,
   input  logic      cdb_valid,

   output mem_req_t  issue_req,
   output logic      issue_valid,
   input  logic      issue_ready
);

   // one queue slot that keeps its address ready so the head can issue at once
   typedef struct packed {
      logic                valid;
      ls_op_e              op;
      logic [offset_w-1:0] offset;
      word_t               addr;
      tag_t                rs_tag;
      word_t               rs_data;
      logic                rs_valid;
      tag_t                rt_tag;
      word_t               rt_data;
      logic                rt_valid;
   } lsq_entry_t;

   // registered entries where entry 0 is the oldest instruction
   lsq_entry_t ent_q [lsq_depth];

   // incoming dispatch seen as one more entry sitting above the top
   lsq_entry_t ent_in;

   // every entry plus the incoming one after the cdb snoop
   lsq_entry_t ent_upd [lsq_depth+1];

   // next state of the registered entries
   lsq_entry_t ent_nxt [lsq_depth];

   logic [lsq_cnt_w-1:0] used_cnt;
   logic [lsq_cnt_w-1:0] free_slot;
   logic                 head_leave;
   logic                 dispatch_fire;

   // effective address is base plus the sign extended immediate
   function automatic word_t form_addr(word_t base, logic [offset_w-1:0] off);
      word_t off_ext;
      off_ext = {{(data_w-offset_w){off[offset_w-1]}}, off};
      return base + off_ext;
   endfunction

   // apply a cdb broadcast to one entry
   // a base that arrives here also forms the address in the same edge
   function automatic lsq_entry_t snoop(lsq_entry_t e, cdb_t bus, logic bus_valid);
      lsq_entry_t r;
      r = e;
      if (bus_valid && !e.rs_valid && e.rs_tag == bus.tag) begin
         r.rs_data  = bus.data;
         r.rs_valid = 1'b1;
         r.addr     = form_addr(bus.data, e.offset);
      end
      // a load never waits on rt because its rt_valid is set at dispatch
      if (bus_valid && !e.rt_valid && e.rt_tag == bus.tag) begin
         r.rt_data  = bus.data;
         r.rt_valid = 1'b1;
      end
      return r;
   endfunction

   // the queue stays packed at the bottom, so the count also
   // points at the lowest free entry
   always_comb begin
      used_cnt = '0;
      for (int i = 0; i < lsq_depth; i++) begin
         used_cnt = used_cnt + lsq_cnt_w'(ent_q[i].valid);
      end
   end

   // only the head may issue, which keeps loads and stores in program order
   // a load needs its base only and a store needs base and data
   assign issue_valid = ent_q[0].valid && ent_q[0].rs_valid &&
                        (ent_q[0].rt_valid || ent_q[0].op == op_load);

   assign issue_req.op   = ent_q[0].op;
   assign issue_req.tag  = ent_q[0].rt_tag;
   assign issue_req.addr = ent_q[0].addr;
   assign issue_req.data = ent_q[0].rt_data;

   assign head_leave = issue_valid && issue_ready;

   // full queue still accepts when the head leaves in this cycle
   assign dispatch_ready = (used_cnt != lsq_cnt_w'(lsq_depth)) || head_leave;
   assign dispatch_fire  = dispatch_valid && dispatch_ready;

   // after a head departure every entry moves down one place
   assign free_slot = used_cnt - lsq_cnt_w'(head_leave);

   // build the extra top entry straight from the dispatch port
   always_comb begin
      ent_in.valid    = dispatch_fire;
      ent_in.op       = dispatch.op;
      ent_in.offset   = dispatch.offset;
      // only meaningful when the base is already known and otherwise formed on capture
      ent_in.addr     = form_addr(dispatch.rs_data, dispatch.offset);
      ent_in.rs_tag   = dispatch.rs_tag;
      ent_in.rs_data  = dispatch.rs_data;
      ent_in.rs_valid = dispatch.rs_valid;
      ent_in.rt_tag   = dispatch.rt_tag;
      ent_in.rt_data  = dispatch.rt_data;
      // a load has no source in rt and counts it as resolved from the start
      ent_in.rt_valid = dispatch.rt_valid || (dispatch.op == op_load);
   end

   // all entries watch the bus including the incoming one
   always_comb begin
      for (int i = 0; i < lsq_depth; i++) begin
         ent_upd[i] = snoop(ent_q[i], cdb, cdb_valid);
      end
      ent_upd[lsq_depth] = snoop(ent_in, cdb, cdb_valid);
   end

   // one rule for every slot
   // take the entry above when the head leaves and otherwise keep its own
   // the lowest free slot takes the new instruction, and no other slot may
   always_comb begin : next_sel
      int src;
      for (int i = 0; i < lsq_depth; i++) begin
         src        = i + int'(head_leave);
         ent_nxt[i] = ent_upd[src];
         if (lsq_cnt_w'(i) == free_slot) begin
            ent_nxt[i] = ent_upd[lsq_depth];
         end else if (src == lsq_depth) begin
            ent_nxt[i].valid = 1'b0;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < lsq_depth; i++) begin
            ent_q[i] <= '0;
         end
      end else begin
         for (int i = 0; i < lsq_depth; i++) begin
            ent_q[i] <= ent_nxt[i];
         end
      end
   end

endmodule

// ==== design/ls_mem_unit.sv ====
`timescale 1ns/10ps

module ls_mem_unit
   import ls_isa_pkg::*, ls_bus_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,

   input  mem_req_t issue_req,
   input  logic     issue_valid,
   output logic     issue_ready,

   output cdb_t     load_result,
   output logic     load_valid,
   input  logic     load_ready
);

   // word addressed data memory, bits 1:0 of the address are ignored
   word_t mem_q [mem_words];

   // single entry holding the load result until the arbiter takes it
   cdb_t res_q;
   logic res_valid_q;

   logic                 accept;
   logic [mem_idx_w-1:0] word_idx;

   assign word_idx = issue_req.addr[mem_idx_w+1:2];

   // a new request fits when the result slot is empty or drains now
   // stores never fill the slot but are held back the same way to keep order
   assign issue_ready = !res_valid_q || load_ready;
   assign accept      = issue_valid && issue_ready;

   // stores complete at the accept edge and produce no result
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < mem_words; i++) begin
            mem_q[i] <= '0;
         end
      end else if (accept && issue_req.op == op_store) begin
         mem_q[word_idx] <= issue_req.data;
      end
   end

   // result slot occupancy, a load refilling it in the drain cycle keeps it set
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         res_valid_q <= 1'b0;
      end else if (accept && issue_req.op == op_load) begin
         res_valid_q <= 1'b1;
      end else if (load_ready) begin
         res_valid_q <= 1'b0;
      end
   end

   // the load reads the array at the accept edge
   always_ff @(posedge clk) begin
      if (accept && issue_req.op == op_load) begin
         res_q.tag  <= issue_req.tag;
         res_q.data <= mem_q[word_idx];
      end
   end

   assign load_result = res_q;
   assign load_valid  = res_valid_q;

endmodule

// ==== design/ls_subsystem.sv ====
`timescale 1ns/10ps

module ls_subsystem
   import ls_bus_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,

   input  dispatch_t dispatch,
   input  logic      dispatch_valid,
   output logic      dispatch_ready,

   input  cdb_t      ext_result,
   input  logic      ext_valid,
   output logic      ext_ready,

   output cdb_t      cdb,
   output logic      cdb_valid
);

   // queue head to memory unit
   mem_req_t issue_req;
   logic     issue_valid;
   logic     issue_ready;

   // memory unit to arbiter
   cdb_t     load_result;
   logic     load_valid;
   logic     load_ready;

   // the broadcast bus also feeds the queue snoop port
   ls_issue_queue u_queue (
      .clk            (clk),
      .rst_n          (rst_n),
      .dispatch       (dispatch),
      .dispatch_valid (dispatch_valid),
      .dispatch_ready (dispatch_ready),
      .cdb            (cdb),
      .cdb_valid      (cdb_valid),
      .issue_req      (issue_req),
      .issue_valid    (issue_valid),
      .issue_ready    (issue_ready)
   );

   ls_mem_unit u_mem (
      .clk         (clk),
      .rst_n       (rst_n),
      .issue_req   (issue_req),
      .issue_valid (issue_valid),
      .issue_ready (issue_ready),
      .load_result (load_result),
      .load_valid  (load_valid),
      .load_ready  (load_ready)
   );

   cdb_arbiter u_arb (
      .clk         (clk),
      .rst_n       (rst_n),
      .load_result (load_result),
      .load_valid  (load_valid),
      .load_ready  (load_ready),
      .ext_result  (ext_result),
      .ext_valid   (ext_valid),
      .ext_ready   (ext_ready),
      .cdb         (cdb),
      .cdb_valid   (cdb_valid)
   );

endmodule

// ==== ls_subsystem.f ====
design/ls_isa_pkg.sv
design/ls_bus_pkg.sv
design/ls_issue_queue.sv
design/ls_mem_unit.sv
design/cdb_arbiter.sv
design/ls_subsystem.sv
sim/ls_subsystem_sva.sv
sim/ls_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build from the file list, run the testbench and keep its output in sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module ls_subsystem_tb -f ls_subsystem.f &&
./obj_dir/Vls_subsystem_tb > sim.log 2>&1
status=$?
cat sim.log 2>/dev/null
# a failed build or run, or the fail message in the log, counts as failure
[ "$status" -eq 0 ] && ! grep -q "Finished with errors" sim.log && echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== sim/ls_subsystem_sva.sv ====
`timescale 1ns/10ps

module ls_subsystem_sva
   import ls_bus_pkg::*;
(
   input logic      clk,
   input logic      rst_n,
   input dispatch_t dispatch,
   input logic      dispatch_valid,
   input logic      dispatch_ready,
   input mem_req_t  issue_req,
   input logic      issue_valid,
   input logic      issue_ready,
   input logic      load_valid,
   input logic      ext_valid,
   input logic      grant_ext
);

   // a stalled dispatch keeps its instruction until the queue takes it
   dispatch_stable: assert property (@(posedge clk) disable iff (!rst_n)
      dispatch_valid && !dispatch_ready |=> dispatch_valid && $stable(dispatch))
      else $error("dispatch instruction changed while the queue was full");

   // two contested cycles in a row never go to the same source
   contest_alternate: assert property (@(posedge clk) disable iff (!rst_n)
      load_valid && ext_valid |=>
         !(load_valid && ext_valid) || (grant_ext != $past(grant_ext)))
      else $error("one source won two contested cycles in a row");

   // a head that waits for the memory unit keeps its request on the port
   issue_stable: assert property (@(posedge clk) disable iff (!rst_n)
      issue_valid && !issue_ready |=> issue_valid && $stable(issue_req))
      else $error("issue request changed while the memory unit was busy");

endmodule

// the queue instance never sees an arbiter contest
bind ls_issue_queue ls_subsystem_sva queue_sva (
   .clk(clk), .rst_n(rst_n), .dispatch(dispatch), .dispatch_valid(dispatch_valid),
   .dispatch_ready(dispatch_ready), .issue_req(issue_req), .issue_valid(issue_valid),
   .issue_ready(issue_ready), .load_valid(1'b0), .ext_valid(1'b0), .grant_ext(1'b0)
);

// the arbiter instance sees idle queue handshakes
bind cdb_arbiter ls_subsystem_sva arb_sva (
   .clk(clk), .rst_n(rst_n), .dispatch('0), .dispatch_valid(1'b0),
   .dispatch_ready(1'b1), .issue_req('0), .issue_valid(1'b0), .issue_ready(1'b1),
   .load_valid(load_valid), .ext_valid(ext_valid), .grant_ext(grant_ext)
);

// ==== sim/ls_subsystem_tb.sv ====
`timescale 1ns/10ps

module ls_subsystem_tb
   import ls_isa_pkg::*, ls_bus_pkg::*;
;
   // instruction counts per test, they size the cycle limit
   localparam int batch_len   = 10;
   localparam int rand_batch  = 20;
   localparam int n_instr     = 3 + 4 + 2 + 4 + 6 + batch_len * rand_batch;
   localparam int cycle_limit = 40 * n_instr + 100;
   // tags from here up are only used by the free running ext stream
   localparam int filler_tag0 = 48;

   logic clk, rst_n, dispatch_valid, dispatch_ready, ext_valid, ext_ready, cdb_valid;
   dispatch_t dispatch;
   cdb_t ext_result, cdb;

   logic [15:0] lfsr = 16'd16356;
   word_t ref_mem [mem_words];
   dispatch_t batch_q [$];
   cdb_t pend_q [$], exp_load [$], exp_ext [$];
   int pend_idx [$];
   int next_tag = 0, dispatched = 0, cycle_cnt = 0, starve = 0;
   integer seen_cnt = 0, exp_total = 0;
   logic hold_ext = 1'b0, stream_on = 1'b0;
   string test_name = "reset";

   ls_subsystem dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // galois form of x^16 + x^14 + x^13 + x^11 + 1, one step per bit handed out
   function automatic word_t rand_bits(int n);
      word_t r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
         r = {r[data_w-2:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic cdb_t mk_cdb(tag_t t, word_t v);
      cdb_t c;
      c.tag = t;
      c.data = v;
      return c;
   endfunction

   function automatic tag_t take_tag();
      tag_t t;
      t = tag_t'(next_tag);
      next_tag = next_tag + 1;
      return t;
   endfunction

   // effective address, base plus the sign extended immediate
   function automatic word_t eff_addr(word_t base, logic [offset_w-1:0] off);
      return base + {{(data_w-offset_w){off[offset_w-1]}}, off};
   endfunction

   // reference model, memory updated in program order, word picked by bits 7 to 2
   function automatic word_t ref_apply(ls_op_e op, word_t addr, word_t data);
      if (op == op_store) begin
         ref_mem[addr[7:2]] = data;
         return '0;
      end
      return ref_mem[addr[7:2]];
   endfunction

   task automatic fail_run(string msg);
      $display("%s", msg);
      $display("Finished with errors");
      $fatal(1, "stopped at the first failing check");
   endtask

   task automatic check_cdb(cdb_t exp, cdb_t act);
      if (exp !== act) begin
         $display("Mismatch in %s: expected tag %0d data %h, actual tag %0d data %h",
                  test_name, exp.tag, exp.data, act.tag, act.data);
         fail_run("broadcast result differs from the reference model");
      end
   endtask

   task automatic check_count(string what, integer exp, integer act);
      if (exp !== act) begin
         $display("Mismatch in %s (%s): expected %0d, actual %0d", test_name, what, exp, act);
         fail_run("count differs from the expected value");
      end
   endtask

   // queue one instruction, the unresolved operands go to the ext supply list
   task automatic add_instr(ls_op_e op, word_t base, logic [offset_w-1:0] off,
                            word_t sdata, logic base_ok, logic data_ok);
      dispatch_t d;
      word_t val;
      d = '0;
      d.op = op;
      d.offset = off;
      d.rs_valid = base_ok;
      // a base that is not yet valid carries junk that must never be used
      d.rs_data = base_ok ? base : ~base;
      if (!base_ok) begin
         d.rs_tag = take_tag();
         pend_q.push_back(mk_cdb(d.rs_tag, base));
         pend_idx.push_back(batch_q.size());
      end
      val = ref_apply(op, eff_addr(base, off), sdata);
      if (op == op_load) begin
         d.rt_tag = take_tag();
         d.rt_valid = 1'b1;
         exp_load.push_back(mk_cdb(d.rt_tag, val));
         exp_total = exp_total + 1;
      end else begin
         d.rt_valid = data_ok;
         d.rt_data = data_ok ? sdata : ~sdata;
         if (!data_ok) begin
            d.rt_tag = take_tag();
            pend_q.push_back(mk_cdb(d.rt_tag, sdata));
            pend_idx.push_back(batch_q.size());
         end
      end
      batch_q.push_back(d);
   endtask

   task automatic random_instr();
      word_t r_op, r_base, r_off, r_data, r_ok;
      r_op = rand_bits(1);
      r_base = rand_bits(6);
      r_off = rand_bits(5);
      r_data = rand_bits(data_w);
      r_ok = rand_bits(2);
      add_instr(r_op[0] ? op_store : op_load, {24'd0, r_base[5:0], 2'b00},
                {{(offset_w-5){r_off[4]}}, r_off[4:0]}, r_data, r_ok[0], r_ok[1]);
   endtask

   task automatic drive_dispatch(dispatch_t d);
      @(negedge clk);
      dispatch = d;
      dispatch_valid = 1'b1;
      do @(posedge clk); while (!dispatch_ready);
   endtask

   // the expected entry is queued as soon as the result is offered
   task automatic send_ext(cdb_t r);
      @(negedge clk);
      ext_result = r;
      ext_valid = 1'b1;
      exp_ext.push_back(r);
      exp_total = exp_total + 1;
      do @(posedge clk); while (!ext_ready);
   endtask

   // a missing operand is broadcast only once its instruction sits in the queue
   task automatic supply_operands();
      word_t gap;
      for (int j = 0; j < pend_q.size(); j++) begin
         while (hold_ext || dispatched <= pend_idx[j]) begin
            @(negedge clk);
            ext_valid = 1'b0;
         end
         gap = rand_bits(2);
         repeat (gap[1:0]) begin
            @(negedge clk);
            ext_valid = 1'b0;
         end
         send_ext(pend_q[j]);
      end
      if (pend_q.size() != 0) begin
         @(negedge clk);
         ext_valid = 1'b0;
      end
   endtask

   // back to back ext results, ext_valid never drops while this runs
   task automatic stream_ext();
      int k;
      k = 0;
      while (stream_on) begin
         send_ext(mk_cdb(tag_t'(filler_tag0 + (k % 16)), rand_bits(data_w)));
         k = k + 1;
      end
      @(negedge clk);
      ext_valid = 1'b0;
   endtask

   task automatic run_batch();
      fork
         begin
            for (int i = 0; i < batch_q.size(); i++) begin
               drive_dispatch(batch_q[i]);
               dispatched = i + 1;
            end
            @(negedge clk);
            dispatch_valid = 1'b0;
         end
         supply_operands();
      join
   endtask

   // tags are only reused once every result of the batch has been seen
   task automatic drain_batch();
      while (exp_load.size() != 0 || exp_ext.size() != 0) @(posedge clk);
      batch_q.delete();
      pend_q.delete();
      pend_idx.delete();
      next_tag = 0;
      dispatched = 0;
   endtask

   // each broadcast is matched against the ext list or the load list
   always @(posedge clk) begin
      if (rst_n && cdb_valid) begin
         seen_cnt = seen_cnt + 1;
         if (ext_valid && ext_ready) begin
            if (exp_ext.size() == 0) fail_run("ext result on the bus that was never sent");
            check_cdb(exp_ext.pop_front(), cdb);
         end else begin
            if (exp_load.size() == 0) fail_run("load result on the bus with no load pending");
            check_cdb(exp_load.pop_front(), cdb);
         end
      end
      // a waiting ext result must win the next contested cycle
      starve = (rst_n && ext_valid && !ext_ready) ? starve + 1 : 0;
      if (starve > 1) fail_run("ext producer lost two arbitration cycles in a row");
   end

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > cycle_limit) fail_run("timeout, the tests did not finish in time");
   end

   initial begin : main
      rst_n = 1'b0;
      dispatch = '0;
      dispatch_valid = 1'b0;
      ext_result = '0;
      ext_valid = 1'b0;
      for (int i = 0; i < mem_words; i++) ref_mem[i] = '0;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check_count("dispatch_ready after reset", 1, int'(dispatch_ready));
      check_count("ext_ready after reset", 1, int'(ext_ready));

      test_name = "t1_store_load";
      add_instr(op_store, 32'h40, 16'h0004, 32'hDEADBEEF, 1'b1, 1'b1);
      add_instr(op_load, 32'h40, 16'h0004, '0, 1'b1, 1'b1);
      add_instr(op_load, 32'h80, 16'h0000, '0, 1'b1, 1'b1);
      run_batch();
      drain_batch();

      // late bases with negative and positive offsets
      test_name = "t2_late_base";
      add_instr(op_store, 32'h30, 16'hFFF8, 32'h12345678, 1'b0, 1'b1);
      add_instr(op_load, 32'h20, 16'h0008, '0, 1'b0, 1'b1);
      add_instr(op_store, 32'h40, 16'h0010, 32'h0BADF00D, 1'b0, 1'b1);
      add_instr(op_load, 32'h60, 16'hFFF0, '0, 1'b1, 1'b1);
      run_batch();
      drain_batch();

      test_name = "t3_late_data";
      add_instr(op_store, 32'h10, 16'h0000, 32'hCAFE0001, 1'b1, 1'b0);
      add_instr(op_load, 32'h10, 16'h0000, '0, 1'b1, 1'b1);
      run_batch();
      drain_batch();

      test_name = "t4_ext_stream";
      add_instr(op_load, 32'h28, 16'h0000, '0, 1'b1, 1'b1);
      add_instr(op_load, 32'h10, 16'h0000, '0, 1'b1, 1'b1);
      add_instr(op_load, 32'h44, 16'h0000, '0, 1'b1, 1'b1);
      add_instr(op_load, 32'hF0, 16'h0000, '0, 1'b1, 1'b1);
      stream_on = 1'b1;
      fork
         begin
            run_batch();
            while (exp_load.size() != 0) @(posedge clk);
            stream_on = 1'b0;
         end
         stream_ext();
      join
      drain_batch();

      // the head base is held back so the queue fills behind it
      test_name = "t5_backpressure";
      add_instr(op_load, 32'h44, 16'h0000, '0, 1'b0, 1'b1);
      add_instr(op_store, 32'h70, 16'h0000, 32'h5555AAAA, 1'b1, 1'b1);
      add_instr(op_load, 32'h70, 16'h0000, '0, 1'b1, 1'b1);
      add_instr(op_store, 32'h74, 16'h0000, 32'h0F0F0F0F, 1'b1, 1'b1);
      add_instr(op_load, 32'h74, 16'h0000, '0, 1'b1, 1'b1);
      add_instr(op_load, 32'h28, 16'h0000, '0, 1'b1, 1'b1);
      hold_ext = 1'b1;
      fork
         run_batch();
         begin
            wait (dispatched == 4);
            repeat (4) begin
               @(negedge clk);
               check_count("accepted while stalled", 4, dispatched);
               check_count("dispatch_ready while full", 0, int'(dispatch_ready));
            end
            hold_ext = 1'b0;
         end
      join
      drain_batch();

      test_name = "t6_random_mix";
      for (int b = 0; b < rand_batch; b++) begin
         for (int k = 0; k < batch_len; k++) random_instr();
         run_batch();
         drain_batch();
      end

      test_name = "final";
      repeat (4) @(posedge clk);
      check_count("results on the bus", exp_total, seen_cnt);
      if (seen_cnt == exp_total) begin
         $display("Finished with no errors");
         $finish;
      end else begin
         $display("Finished with errors");
         $fatal(1, "result count check failed");
      end
   end

endmodule
